/* source/uplink_defs.svh */
`ifndef UPLINK_DEFS_SVH
`define UPLINK_DEFS_SVH

//////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////

// Byte address width of the AXI4-Lite port
`define UPLINK_ADDR_W 11
// Data width, one register per 32-bit word
`define UPLINK_DATA_W 32

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// Number of implemented words
`define UPLINK_REG_N 2
// Control word, read/write
`define UPLINK_REG_CTRL 0
// Status word, read-only
`define UPLINK_REG_STAT 1

// Flop depth of every clock crossing
`define UPLINK_SYNC_STAGES 2

`endif

/* source/axil_pkg.sv */
`include "uplink_defs.svh"

package axil_pkg;

  // Byte address as seen on AWADDR and ARADDR
  typedef logic [`UPLINK_ADDR_W-1:0] axil_addr_t;

  // Write and read data
  typedef logic [`UPLINK_DATA_W-1:0] axil_data_t;

  // One strobe bit per byte lane
  typedef logic [`UPLINK_DATA_W/8-1:0] axil_strb_t;

  // BRESP and RRESP encoding
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  // Out of range word
  localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

/* source/uplink_pkg.sv */
`include "uplink_defs.svh"

package uplink_pkg;

  // Word index into the register map
  typedef logic [$clog2(`UPLINK_REG_N)-1:0] reg_idx_t;

  // Packed status word
  // Bit 0 uplink ready, bit 1 FEC flag
  // Bits 3:2 EC data, bits 5:4 IC data, bits 8:6 phase
  // Bit 9 MGT ready, bits 19:10 bitslip count
  // Bits 20 to 26 header locked, gearbox ready, datapath reset,
  // pattern-search reset, gearbox reset, header flag, ready debug
  // Bits 31:27 read zero
  typedef logic [`UPLINK_DATA_W-1:0] status_word_t;

  // Uplink phase field
  typedef logic [2:0] phase_t;

  // Bitslip counter from the frame aligner
  typedef logic [9:0] slip_cnt_t;

  // Control word bit positions
  localparam int CTRL_BIT_RST = 0;
  localparam int CTRL_BIT_POL = 1;

endpackage

/* source/axil_reg_slave.sv */
`timescale 1ns/1ps
`include "uplink_defs.svh"

module axil_reg_slave (
  input  logic                 S_AXI_ACLK,
  input  logic                 S_AXI_ARESETN,
  // Write address and data
  input  axil_pkg::axil_addr_t S_AXI_AWADDR,
  input  logic [2:0]           S_AXI_AWPROT,
  input  logic                 S_AXI_AWVALID,
  output logic                 S_AXI_AWREADY,
  input  axil_pkg::axil_data_t S_AXI_WDATA,
  input  axil_pkg::axil_strb_t S_AXI_WSTRB,
  input  logic                 S_AXI_WVALID,
  output logic                 S_AXI_WREADY,
  // Write response
  output axil_pkg::axil_resp_t S_AXI_BRESP,
  output logic                 S_AXI_BVALID,
  input  logic                 S_AXI_BREADY,
  // Read address and data
  input  axil_pkg::axil_addr_t S_AXI_ARADDR,
  input  logic [2:0]           S_AXI_ARPROT,
  input  logic                 S_AXI_ARVALID,
  output logic                 S_AXI_ARREADY,
  output axil_pkg::axil_data_t S_AXI_RDATA,
  output axil_pkg::axil_resp_t S_AXI_RRESP,
  output logic                 S_AXI_RVALID,
  input  logic                 S_AXI_RREADY,
  // Register block side
  output logic                 wr_en_o,
  output uplink_pkg::reg_idx_t wr_idx_o,
  output axil_pkg::axil_data_t wr_data_o,
  output axil_pkg::axil_strb_t wr_strb_o,
  output uplink_pkg::reg_idx_t rd_idx_o,
  input  axil_pkg::axil_data_t rd_data_i
);
  import axil_pkg::*;
  import uplink_pkg::*;

  // Word address, byte offset dropped
  typedef logic [`UPLINK_ADDR_W-3:0] word_t;

  word_t      aw_word;
  word_t      ar_word;
  logic       aw_hit;
  logic       ar_hit;
  logic       awready_q;
  logic       arready_q;
  logic       bvalid_q;
  logic       rvalid_q;
  logic       wr_fire;
  logic       rd_fire;
  axil_resp_t bresp_q;
  axil_resp_t rresp_q;
  axil_data_t rdata_q;

  // Decode and range check
  assign aw_word = S_AXI_AWADDR[`UPLINK_ADDR_W-1:2];
  assign ar_word = S_AXI_ARADDR[`UPLINK_ADDR_W-1:2];
  assign aw_hit  = aw_word < word_t'(`UPLINK_REG_N);
  assign ar_hit  = ar_word < word_t'(`UPLINK_REG_N);

  //////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////

  // Handshake cycle, address and data taken together
  assign wr_fire = awready_q && S_AXI_AWVALID && S_AXI_WVALID;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      // One-cycle ready pulse, blocked while a response waits
      awready_q <= !awready_q && S_AXI_AWVALID && S_AXI_WVALID && !bvalid_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (S_AXI_BREADY) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_fire) begin
      bresp_q <= aw_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Strobe only for words that exist
  assign wr_en_o   = wr_fire && aw_hit;
  assign wr_idx_o  = aw_word[$bits(reg_idx_t)-1:0];
  assign wr_data_o = S_AXI_WDATA;
  assign wr_strb_o = S_AXI_WSTRB;

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////

  assign rd_fire  = arready_q && S_AXI_ARVALID;
  assign rd_idx_o = ar_word[$bits(reg_idx_t)-1:0];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= !arready_q && S_AXI_ARVALID && !rvalid_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (S_AXI_RREADY) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Read data captured once, held through back-pressure
  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_fire) begin
      rdata_q <= ar_hit ? rd_data_i : '0;
      rresp_q <= ar_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign S_AXI_AWREADY = awready_q;
  assign S_AXI_WREADY  = awready_q;
  assign S_AXI_BVALID  = bvalid_q;
  assign S_AXI_BRESP   = bresp_q;
  assign S_AXI_ARREADY = arready_q;
  assign S_AXI_RVALID  = rvalid_q;
  assign S_AXI_RDATA   = rdata_q;
  assign S_AXI_RRESP   = rresp_q;

  // Response held with its code until the master takes it
  a_bvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid_q && !S_AXI_BREADY |=> bvalid_q && $stable(bresp_q));
  a_rvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid_q && !S_AXI_RREADY |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));
  // Single outstanding write
  a_no_wr_pending : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid_q |-> !wr_en_o);

endmodule

/* source/uplink_csr.sv */
`timescale 1ns/1ps
`include "uplink_defs.svh"

module uplink_csr (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // Write strobe from the bus slave
  input  logic                     wr_en_i,
  input  uplink_pkg::reg_idx_t     wr_idx_i,
  input  axil_pkg::axil_data_t     wr_data_i,
  input  axil_pkg::axil_strb_t     wr_strb_i,
  // Read select and data
  input  uplink_pkg::reg_idx_t     rd_idx_i,
  output axil_pkg::axil_data_t     rd_data_o,
  // Status already in the bus domain
  input  uplink_pkg::status_word_t status_i,
  output axil_pkg::axil_data_t     ctrl_o
);
  import axil_pkg::*;
  import uplink_pkg::*;

  axil_data_t ctrl_q;
  logic       ctrl_sel;

  // Status has no storage here, writes to it fall through
  assign ctrl_sel = wr_en_i && (wr_idx_i == reg_idx_t'(`UPLINK_REG_CTRL));

  //////////////////////////////////////////////////
  // Control word
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ctrl_q <= '0;
    end else if (ctrl_sel) begin
      // Byte lanes updated one by one
      for (int b = 0; b < `UPLINK_DATA_W / 8; b++) begin
        if (wr_strb_i[b]) begin
          ctrl_q[b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  assign ctrl_o = ctrl_q;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    case (rd_idx_i)
      reg_idx_t'(`UPLINK_REG_CTRL): rd_data_o = ctrl_q;
      reg_idx_t'(`UPLINK_REG_STAT): rd_data_o = status_i;
      default:                      rd_data_o = '0;
    endcase
  end

  // Empty strobe means no lane moves
  a_zero_strb : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    wr_en_i && (wr_strb_i == '0) |=> ctrl_q == $past(ctrl_q));

endmodule

/* source/uplink_cdc.sv */
`timescale 1ns/1ps
`include "uplink_defs.svh"

module uplink_cdc (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic                     clk40_i,
  // Link status, clk40_i domain
  input  logic                     uplink_rdy_i,
  input  logic                     uplink_fec_i,
  input  logic [1:0]               ec_data_i,
  input  logic [1:0]               ic_data_i,
  input  uplink_pkg::phase_t       phase_i,
  input  logic                     mgt_rx_rdy_i,
  input  uplink_pkg::slip_cnt_t    bitslip_cnt_i,
  input  logic                     header_locked_i,
  input  logic                     gb_rdy_i,
  input  logic                     datapath_rst_i,
  input  logic                     pattsearch_rst_i,
  input  logic                     gearbox_rst_i,
  input  logic                     header_flag_i,
  input  logic                     uplink_ready_dbg_i,
  // Polarity, bus domain
  input  logic                     pol_i,
  output uplink_pkg::status_word_t status_o,
  output logic                     rx_polarity_o
);
  import uplink_pkg::*;

  status_word_t                   stat_src;
  status_word_t                   stat_sync_q [`UPLINK_SYNC_STAGES];
  logic [`UPLINK_SYNC_STAGES-1:0] pol_sync_q;

  // Status layout, top five bits tied low
  assign stat_src = {5'b0, uplink_ready_dbg_i, header_flag_i, gearbox_rst_i,
                     pattsearch_rst_i, datapath_rst_i, gb_rdy_i, header_locked_i,
                     bitslip_cnt_i, mgt_rx_rdy_i, phase_i, ic_data_i, ec_data_i,
                     uplink_fec_i, uplink_rdy_i};

  //////////////////////////////////////////////////
  // Link to bus clock
  //////////////////////////////////////////////////

  // Fields are quasi-static, plain flop chain per bit
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < `UPLINK_SYNC_STAGES; i++) begin
        stat_sync_q[i] <= '0;
      end
    end else begin
      stat_sync_q[0] <= stat_src;
      for (int i = 1; i < `UPLINK_SYNC_STAGES; i++) begin
        stat_sync_q[i] <= stat_sync_q[i-1];
      end
    end
  end

  assign status_o = stat_sync_q[`UPLINK_SYNC_STAGES-1];

  //////////////////////////////////////////////////
  // Bus to link clock
  //////////////////////////////////////////////////

  // Reset sampled on clk40_i, long enough to be seen
  always_ff @(posedge clk40_i) begin
    if (!S_AXI_ARESETN) begin
      pol_sync_q <= '0;
    end else begin
      pol_sync_q <= {pol_sync_q[`UPLINK_SYNC_STAGES-2:0], pol_i};
    end
  end

  assign rx_polarity_o = pol_sync_q[`UPLINK_SYNC_STAGES-1];

endmodule

/* source/uplink_ctrl_top.sv */
`timescale 1ns/1ps

module uplink_ctrl_top (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // AXI4-Lite slave port
  input  axil_pkg::axil_addr_t  S_AXI_AWADDR,
  input  logic [2:0]            S_AXI_AWPROT,
  input  logic                  S_AXI_AWVALID,
  output logic                  S_AXI_AWREADY,
  input  axil_pkg::axil_data_t  S_AXI_WDATA,
  input  axil_pkg::axil_strb_t  S_AXI_WSTRB,
  input  logic                  S_AXI_WVALID,
  output logic                  S_AXI_WREADY,
  output axil_pkg::axil_resp_t  S_AXI_BRESP,
  output logic                  S_AXI_BVALID,
  input  logic                  S_AXI_BREADY,
  input  axil_pkg::axil_addr_t  S_AXI_ARADDR,
  input  logic [2:0]            S_AXI_ARPROT,
  input  logic                  S_AXI_ARVALID,
  output logic                  S_AXI_ARREADY,
  output axil_pkg::axil_data_t  S_AXI_RDATA,
  output axil_pkg::axil_resp_t  S_AXI_RRESP,
  output logic                  S_AXI_RVALID,
  input  logic                  S_AXI_RREADY,
  // Link clock and status
  input  logic                  clk40_i,
  input  logic                  uplink_rdy_i,
  input  logic                  uplink_fec_i,
  input  logic [1:0]            ec_data_i,
  input  logic [1:0]            ic_data_i,
  input  uplink_pkg::phase_t    phase_i,
  input  logic                  mgt_rx_rdy_i,
  input  uplink_pkg::slip_cnt_t bitslip_cnt_i,
  input  logic                  header_locked_i,
  input  logic                  gb_rdy_i,
  input  logic                  datapath_rst_i,
  input  logic                  pattsearch_rst_i,
  input  logic                  gearbox_rst_i,
  input  logic                  header_flag_i,
  input  logic                  uplink_ready_dbg_i,
  // Uplink controls
  output logic                  uplink_rst_o,
  output logic                  rx_polarity_o
);
  import axil_pkg::*;
  import uplink_pkg::*;

  logic         wr_en;
  reg_idx_t     wr_idx;
  axil_data_t   wr_data;
  axil_strb_t   wr_strb;
  reg_idx_t     rd_idx;
  axil_data_t   rd_data;
  axil_data_t   ctrl_q;
  status_word_t status;

  // Uplink reset stays in the bus domain, it must act while the link clock is down
  assign uplink_rst_o = ctrl_q[CTRL_BIT_RST];

  axil_reg_slave u_slave (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .S_AXI_AWADDR, .S_AXI_AWPROT, .S_AXI_AWVALID, .S_AXI_AWREADY,
    .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
    .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
    .S_AXI_ARADDR, .S_AXI_ARPROT, .S_AXI_ARVALID, .S_AXI_ARREADY,
    .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
    .wr_en_o   (wr_en),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb),
    .rd_idx_o  (rd_idx),
    .rd_data_i (rd_data)
  );

  uplink_csr u_csr (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .wr_en_i   (wr_en),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data),
    .status_i  (status),
    .ctrl_o    (ctrl_q)
  );

  // Status in from clk40_i, polarity out to clk40_i
  uplink_cdc u_cdc (
    .S_AXI_ACLK, .S_AXI_ARESETN, .clk40_i,
    .uplink_rdy_i, .uplink_fec_i, .ec_data_i, .ic_data_i, .phase_i,
    .mgt_rx_rdy_i, .bitslip_cnt_i, .header_locked_i, .gb_rdy_i,
    .datapath_rst_i, .pattsearch_rst_i, .gearbox_rst_i, .header_flag_i,
    .uplink_ready_dbg_i,
    .pol_i         (ctrl_q[CTRL_BIT_POL]),
    .status_o      (status),
    .rx_polarity_o (rx_polarity_o)
  );

endmodule

/* verification/tb_uplink_ctrl.sv */
`timescale 1ns/1ps

module tb_uplink_ctrl;
  import axil_pkg::*;

  // Eight hex words per golden step
  localparam int COLS       = 8;
  localparam int MAX_STEPS  = 64;
  // Bus cycles allowed for any handshake
  localparam int WAIT_LIMIT = 20;

  logic        aclk;
  logic        aresetn;
  logic        clk40;
  axil_addr_t  awaddr;
  axil_addr_t  araddr;
  logic [2:0]  awprot;
  logic [2:0]  arprot;
  logic        awvalid;
  logic        awready;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic        rready;
  axil_data_t  wdata;
  axil_data_t  rdata;
  axil_strb_t  wstrb;
  axil_resp_t  bresp;
  axil_resp_t  rresp;
  // Link status inputs packed in status word order
  logic [31:0] link;
  logic        uplink_rst;
  logic        rx_polarity;

  logic [31:0] gold [MAX_STEPS*COLS];
  logic [31:0] ctrl_model;
  int          n_steps;
  int          errors;
  int          checks;

  always #50 aclk = ~aclk;
  always #12.5 clk40 = ~clk40;

  uplink_ctrl_top dut0 (
    .S_AXI_ACLK    (aclk),
    .S_AXI_ARESETN (aresetn),
    .S_AXI_AWADDR  (awaddr),
    .S_AXI_AWPROT  (awprot),
    .S_AXI_AWVALID (awvalid),
    .S_AXI_AWREADY (awready),
    .S_AXI_WDATA   (wdata),
    .S_AXI_WSTRB   (wstrb),
    .S_AXI_WVALID  (wvalid),
    .S_AXI_WREADY  (wready),
    .S_AXI_BRESP   (bresp),
    .S_AXI_BVALID  (bvalid),
    .S_AXI_BREADY  (bready),
    .S_AXI_ARADDR  (araddr),
    .S_AXI_ARPROT  (arprot),
    .S_AXI_ARVALID (arvalid),
    .S_AXI_ARREADY (arready),
    .S_AXI_RDATA   (rdata),
    .S_AXI_RRESP   (rresp),
    .S_AXI_RVALID  (rvalid),
    .S_AXI_RREADY  (rready),
    .clk40_i            (clk40),
    .uplink_rdy_i       (link[0]),
    .uplink_fec_i       (link[1]),
    .ec_data_i          (link[3:2]),
    .ic_data_i          (link[5:4]),
    .phase_i            (link[8:6]),
    .mgt_rx_rdy_i       (link[9]),
    .bitslip_cnt_i      (link[19:10]),
    .header_locked_i    (link[20]),
    .gb_rdy_i           (link[21]),
    .datapath_rst_i     (link[22]),
    .pattsearch_rst_i   (link[23]),
    .gearbox_rst_i      (link[24]),
    .header_flag_i      (link[25]),
    .uplink_ready_dbg_i (link[26]),
    .uplink_rst_o       (uplink_rst),
    .rx_polarity_o      (rx_polarity)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Write transfer
  //////////////////////////////////////////////////

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb, input axil_resp_t exp_resp,
                           input int stall);
    int         n;
    axil_resp_t first_resp;
    n = 0;
    @(negedge aclk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (stall == 0);
    do begin
      @(negedge aclk);
      n++;
    end while (!awready && n < WAIT_LIMIT);
    if (!awready) begin
      $display("write to address 0x%03h was never accepted", addr);
      errors++;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      return;
    end
    // Address and data taken in the same cycle
    check_value("WREADY", 32'(wready), 32'd1);
    // Handshake at the next rising edge
    @(negedge aclk);
    // During a stall the valids stay up as a second request
    awvalid = (stall != 0);
    wvalid  = (stall != 0);
    n = 0;
    while (!bvalid && n < WAIT_LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (!bvalid) begin
      $display("no write response for address 0x%03h", addr);
      errors++;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      return;
    end
    // Only word 0 holds storage and merges lane by lane
    if (addr[10:2] == 9'd0) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          ctrl_model[b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    check_value("BRESP", 32'(bresp), 32'(exp_resp));
    check_value("uplink_rst_o", 32'(uplink_rst), 32'(ctrl_model[0]));
    first_resp = bresp;
    repeat (stall) begin
      @(negedge aclk);
      check_value("BVALID", 32'(bvalid), 32'd1);
      check_value("BRESP", 32'(bresp), 32'(first_resp));
      check_value("AWREADY", 32'(awready), 32'd0);
      check_value("WREADY", 32'(wready), 32'd0);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(negedge aclk);
    check_value("BVALID", 32'(bvalid), 32'd0);
    bready = 1'b0;
    // Polarity crosses into clk40
    repeat (4) @(negedge aclk);
    check_value("rx_polarity_o", 32'(rx_polarity), 32'(ctrl_model[1]));
  endtask

  //////////////////////////////////////////////////
  // Read transfer
  //////////////////////////////////////////////////

  task automatic read_reg(input axil_addr_t addr, input axil_resp_t exp_resp,
                          input axil_data_t exp_data, input int stall);
    int         n;
    axil_resp_t first_resp;
    axil_data_t first_data;
    n = 0;
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (stall == 0);
    do begin
      @(negedge aclk);
      n++;
    end while (!arready && n < WAIT_LIMIT);
    if (!arready) begin
      $display("read of address 0x%03h was never accepted", addr);
      errors++;
      arvalid = 1'b0;
      return;
    end
    @(negedge aclk);
    arvalid = (stall != 0);
    n = 0;
    while (!rvalid && n < WAIT_LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (!rvalid) begin
      $display("no read data for address 0x%03h", addr);
      errors++;
      arvalid = 1'b0;
      return;
    end
    check_value("RRESP", 32'(rresp), 32'(exp_resp));
    check_value("RDATA", rdata, exp_data);
    first_resp = rresp;
    first_data = rdata;
    // Payload frozen while RREADY is low
    repeat (stall) begin
      @(negedge aclk);
      check_value("RVALID", 32'(rvalid), 32'd1);
      check_value("RDATA", rdata, first_data);
      check_value("RRESP", 32'(rresp), 32'(first_resp));
      check_value("ARREADY", 32'(arready), 32'd0);
    end
    arvalid = 1'b0;
    rready  = 1'b1;
    @(negedge aclk);
    check_value("RVALID", 32'(rvalid), 32'd0);
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int          s;
    logic [31:0] prev_link;
    aclk       = 1'b0;
    clk40      = 1'b0;
    aresetn    = 1'b0;
    awaddr     = '0;
    araddr     = '0;
    awprot     = 3'b000;
    arprot     = 3'b000;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    link       = '0;
    ctrl_model = '0;
    errors     = 0;
    checks     = 0;
    $readmemh("verification/uplink_golden.txt", gold);
    // Steps end at the line with operation f
    n_steps = 0;
    while (n_steps < MAX_STEPS && gold[n_steps*COLS+1] !== 32'hf) begin
      n_steps++;
    end
    if (n_steps == MAX_STEPS) begin
      $display("golden file has no end line");
      errors++;
    end
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    // Quiet outputs out of reset
    check_value("AWREADY", 32'(awready), 32'd0);
    check_value("WREADY", 32'(wready), 32'd0);
    check_value("ARREADY", 32'(arready), 32'd0);
    check_value("BVALID", 32'(bvalid), 32'd0);
    check_value("RVALID", 32'(rvalid), 32'd0);
    check_value("uplink_rst_o", 32'(uplink_rst), 32'd0);
    check_value("rx_polarity_o", 32'(rx_polarity), 32'd0);
    prev_link = link;
    for (s = 0; s < n_steps; s++) begin
      link = gold[s*COLS];
      // Settle time for the status synchronizers
      if (link != prev_link) begin
        repeat (8) @(negedge aclk);
      end
      prev_link = link;
      case (gold[s*COLS+1])
        32'd1: write_reg(gold[s*COLS+2][10:0], gold[s*COLS+3], gold[s*COLS+4][3:0],
                         gold[s*COLS+5][1:0], int'(gold[s*COLS+7]));
        32'd2: read_reg(gold[s*COLS+2][10:0], gold[s*COLS+5][1:0], gold[s*COLS+6],
                        int'(gold[s*COLS+7]));
        default: repeat (8) @(negedge aclk);
      endcase
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Budget of 60 bus cycles per golden line plus reset
  initial begin : watchdog
    #1;
    #((n_steps + 1) * 60 * 100 + 16 * 100);
    $display("run timed out after %0d golden steps", n_steps);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* verification/uplink_golden.txt */
// Columns: link status (status word order), op (0 idle 1 write 2 read f end), byte address,
// write data, strobe, expected response (0 OKAY 2 SLVERR), expected read data, stall cycles
00000000 2 000 00000000 0 0 00000000 0
00000000 1 000 a5a5a5a5 f 0 00000000 0
00000000 2 000 00000000 0 0 a5a5a5a5 0
00000000 1 000 12345672 5 0 00000000 0
00000000 2 000 00000000 0 0 a534a572 0
00000000 1 000 ffffffff 0 0 00000000 0
00000000 2 000 00000000 0 0 a534a572 0
00000000 1 000 5a000000 8 0 00000000 0
00000000 2 000 00000000 0 0 5a34a572 0
fabcdef3 2 004 00000000 0 0 02bcdef3 0
fabcdef3 1 004 ffffffff f 0 00000000 0
fabcdef3 2 004 00000000 0 0 02bcdef3 0
fabcdef3 2 000 00000000 0 0 5a34a572 0
05432109 2 004 00000000 0 0 05432109 0
00000000 0 000 00000000 0 0 00000000 0
00000000 1 008 ffffffff f 2 00000000 0
00000000 2 008 00000000 0 2 00000000 0
00000000 2 7fc 00000000 0 2 00000000 0
00000000 2 000 00000000 0 0 5a34a572 0
00000000 1 000 00000003 1 0 00000000 5
00000000 2 000 00000000 0 0 5a34a503 4
00000000 2 00c 00000000 0 2 00000000 3
00000000 1 000 00000000 f 0 00000000 0
00000000 2 000 00000000 0 0 00000000 0
00000000 f 000 00000000 0 0 00000000 0

/* uplink_ctrl.f */
+incdir+source
source/axil_pkg.sv
source/uplink_pkg.sv
source/axil_reg_slave.sv
source/uplink_csr.sv
source/uplink_cdc.sv
source/uplink_ctrl_top.sv
verification/tb_uplink_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the uplink control testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_uplink_ctrl
mdir=obj_dir
log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f uplink_ctrl.f --top-module "$top" -Mdir "$mdir" -o "$top"; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$mdir/$top" > "$log" 2>&1; then
  cat "$log"
  echo "Simulation exited with an error"
  exit 1
fi
cat "$log"

if grep -qx "RESULT: PASS" "$log"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
